//--- common/rvPkg.sv
package rvPkg;

    ////////////////////////////////////////////////////////////
    // Base widths
    ////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;     // Data or instruction word
    typedef logic [4:0]  regAddr_t;  // Register index
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [7:0]  operand_t;  // Panel operand or GCD result

    // Opcodes that the core understands
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // R-type funct3
    localparam funct3_t F3_ADDSUB = 3'b000;  // funct7 bit 5 picks sub
    localparam funct3_t F3_SLT    = 3'b010;
    localparam funct3_t F3_XOR    = 3'b100;
    localparam funct3_t F3_OR     = 3'b110;
    localparam funct3_t F3_AND    = 3'b111;

    // Branch funct3
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT} aluOp_t;

    // Unknown opcodes land in CLS_NONE
    typedef enum logic [1:0] {CLS_REG, CLS_LOAD, CLS_BRANCH, CLS_NONE} instrClass_t;

    localparam regAddr_t RESULT_REG = 5'd8;  // x8 holds the GCD

    // Memory-mapped input words
    localparam word_t IO_DONE_ADDR = 32'd0;
    localparam word_t IO_NUM1_ADDR = 32'd1;
    localparam word_t IO_NUM2_ADDR = 32'd2;

endpackage

//--- common/panelPkg.sv
package panelPkg;

    typedef logic [3:0] nibble_t;
    typedef logic [6:0] segments_t;  // Active low, a in bit 6
    typedef logic [7:0] anodes_t;    // Active low

    // Scan order, left to right on the board
    typedef enum logic [2:0] {
        DIG_NUM1_HI = 3'd0,
        DIG_NUM1_LO = 3'd1,
        DIG_NUM2_HI = 3'd2,
        DIG_NUM2_LO = 3'd3,
        DIG_GCD_HI  = 3'd4,
        DIG_GCD_LO  = 3'd5
    } digit_t;

    // Hex glyphs 0..F, segments abcdefg
    localparam segments_t SEG_TABLE [16] = '{
        7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,  // 0 1 2 3
        7'b1001100, 7'b0100100, 7'b0100000, 7'b0001111,  // 4 5 6 7
        7'b0000000, 7'b0000100, 7'b0001000, 7'b1100000,  // 8 9 A b
        7'b0110001, 7'b1000010, 7'b0110000, 7'b0111000   // C d E F
    };

    // Digits 7 6 | 4 3 | 1 0, gaps between the three values
    localparam anodes_t ANODE_TABLE [6] = '{
        8'b0111_1111, 8'b1011_1111, 8'b1110_1111,
        8'b1111_0111, 8'b1111_1101, 8'b1111_1110
    };

endpackage

//--- core/gcdProgramRom.sv
`timescale 1ns/100ps

module gcdProgramRom (
    input  rvPkg::word_t pc,
    output rvPkg::word_t instr
);
    import rvPkg::*;

    localparam int PROG_WORDS = 14;

    // Subtraction GCD, x8 and x9 are the working pair
    localparam word_t PROGRAM [PROG_WORDS] = '{
        32'h0000_0000,  // 00 nop
        32'h0000_2503,  // 04 lw  x10, 0(x0)    done flag
        32'hFEA0_0EE3,  // 08 beq x0, x10, -4   wait for done
        32'h0010_2403,  // 0c lw  x8, 1(x0)     operand one
        32'h0020_2483,  // 10 lw  x9, 2(x0)     operand two
        32'h0094_0C63,  // 14 beq x8, x9, +24   equal means finished
        32'h0094_4663,  // 18 blt x8, x9, +12
        32'h4094_0433,  // 1c sub x8, x8, x9
        32'hFE00_0AE3,  // 20 beq x0, x0, -12
        32'h4084_84B3,  // 24 sub x9, x9, x8
        32'hFE00_06E3,  // 28 beq x0, x0, -20
        32'h0000_2503,  // 2c lw  x10, 0(x0)
        32'hFC05_0AE3,  // 30 beq x10, x0, -44  done dropped, restart
        32'hFE00_0CE3   // 34 beq x0, x0, -8    hold while done high
    };

    logic inRange;

    assign inRange = (pc < word_t'(PROG_WORDS * 4));  // Byte address limit
    assign instr   = inRange ? PROGRAM[pc[5:2]] : '0;  // Zero reads as nop

endmodule

//--- core/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
    input  rvPkg::word_t    instr,
    output rvPkg::regAddr_t rs1,
    output rvPkg::regAddr_t rs2,
    output rvPkg::regAddr_t rd,
    output rvPkg::aluOp_t   aluOp,
    output logic            regWrite,
    output logic            memToReg,
    output logic            isBranch,
    output rvPkg::funct3_t  funct3,
    output rvPkg::word_t    imm
);
    import rvPkg::*;

    opcode_t     opcode;
    logic [6:0]  funct7;
    instrClass_t instrClass;

    ////////////////////////////////////////////////////////////
    // Field split
    ////////////////////////////////////////////////////////////
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb
    begin
        unique case (opcode)
            OP_REG:    instrClass = CLS_REG;
            OP_LOAD:   instrClass = CLS_LOAD;
            OP_BRANCH: instrClass = CLS_BRANCH;
            default:   instrClass = CLS_NONE;  // Acts as a nop
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////
    assign regWrite = (instrClass == CLS_REG) || (instrClass == CLS_LOAD);
    assign memToReg = (instrClass == CLS_LOAD);    // Load data to rd
    assign isBranch = (instrClass == CLS_BRANCH);

    always_comb
    begin
        aluOp = ALU_ADD;  // Loads and branches add
        if (instrClass == CLS_REG)
        begin
            case (funct3)
                F3_ADDSUB: aluOp = funct7[5] ? ALU_SUB : ALU_ADD;
                F3_AND:    aluOp = ALU_AND;
                F3_OR:     aluOp = ALU_OR;
                F3_XOR:    aluOp = ALU_XOR;
                F3_SLT:    aluOp = ALU_SLT;
                default:   aluOp = ALU_ADD;  // Shifts not built
            endcase
        end
    end

    // B-type offset for branches, I-type otherwise
    always_comb
    begin
        if (instrClass == CLS_BRANCH)
            imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        else
            imm = {{20{instr[31]}}, instr[31:20]};
    end

endmodule

//--- core/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    input  rvPkg::regAddr_t rd,
    input  logic            regWrite,
    input  rvPkg::word_t    wrData,
    output rvPkg::word_t    rdData1,
    output rvPkg::word_t    rdData2,
    output rvPkg::word_t    resultReg
);
    import rvPkg::*;

    word_t regs [32];

    // Asynchronous reads with x0 held at zero by the write guard
    assign rdData1   = regs[rs1];
    assign rdData2   = regs[rs2];
    assign resultReg = regs[RESULT_REG];  // GCD tap

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (regWrite && (rd != '0))
        begin
            regs[rd] <= wrData;  // Commit at end of instruction
        end
    end

    // No instruction of the GCD program writes back to x0
    assert property (@(posedge clk) disable iff (rst) !(regWrite && (rd == '0)))
        else $error("write-back aimed at x0");

endmodule

//--- core/execUnit.sv
`timescale 1ns/100ps

module execUnit (
    input  rvPkg::word_t   opA,
    input  rvPkg::word_t   opB,
    input  rvPkg::aluOp_t  aluOp,
    input  logic           isBranch,
    input  rvPkg::funct3_t funct3,
    output rvPkg::word_t   aluResult,
    output logic           branchTaken
);
    import rvPkg::*;

    logic isEqual;
    logic isLess;
    logic condMet;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        unique case (aluOp)
            ALU_ADD: aluResult = opA + opB;  // Also load address
            ALU_SUB: aluResult = opA - opB;
            ALU_AND: aluResult = opA & opB;
            ALU_OR:  aluResult = opA | opB;
            ALU_XOR: aluResult = opA ^ opB;
            ALU_SLT: aluResult = {31'b0, isLess};
            default: aluResult = opA + opB;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Branch compare
    ////////////////////////////////////////////////////////////
    // opB is rs2 for every branch, never the immediate
    assign isEqual = (opA == opB);
    assign isLess  = ($signed(opA) < $signed(opB));  // Signed for slt and blt

    always_comb
    begin
        case (funct3)
            F3_BEQ:  condMet = isEqual;
            F3_BNE:  condMet = !isEqual;
            F3_BLT:  condMet = isLess;
            F3_BGE:  condMet = !isLess;
            default: condMet = 1'b0;  // bltu and bgeu not built
        endcase
    end

    assign branchTaken = isBranch && condMet;

endmodule

//--- core/rvCore.sv
`timescale 1ns/100ps

module rvCore (
    input  logic            clk,
    input  logic            rst,
    input  logic            done,
    input  rvPkg::operand_t num1,
    input  rvPkg::operand_t num2,
    output rvPkg::operand_t gcd
);
    import rvPkg::*;

    word_t    pc;
    word_t    pcNext;
    word_t    instr;
    regAddr_t rs1;
    regAddr_t rs2;
    regAddr_t rd;
    aluOp_t   aluOp;
    logic     regWrite;
    logic     memToReg;
    logic     isBranch;
    funct3_t  funct3;
    word_t    imm;
    word_t    rdData1;
    word_t    rdData2;
    word_t    resultReg;
    word_t    opB;
    word_t    aluResult;
    logic     branchTaken;
    word_t    loadData;
    word_t    wrData;

    gcdProgramRom uRom (.pc(pc), .instr(instr));

    instrDecoder uDecoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .aluOp(aluOp),
        .regWrite(regWrite), .memToReg(memToReg), .isBranch(isBranch),
        .funct3(funct3), .imm(imm)
    );

    regFile uRegFile (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .regWrite(regWrite),
        .wrData(wrData), .rdData1(rdData1), .rdData2(rdData2), .resultReg(resultReg)
    );

    assign opB = memToReg ? imm : rdData2;  // Loads add the offset

    execUnit uExec (
        .opA(rdData1), .opB(opB), .aluOp(aluOp), .isBranch(isBranch),
        .funct3(funct3), .aluResult(aluResult), .branchTaken(branchTaken)
    );

    ////////////////////////////////////////////////////////////
    // IO map and write-back
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        case (aluResult)
            IO_DONE_ADDR: loadData = {31'b0, done};
            IO_NUM1_ADDR: loadData = {24'b0, num1};
            IO_NUM2_ADDR: loadData = {24'b0, num2};
            default:      loadData = '0;  // No data RAM
        endcase
    end

    assign wrData = memToReg ? loadData : aluResult;
    assign gcd    = resultReg[7:0];

    // Branch target is relative to the current pc
    assign pcNext = branchTaken ? (pc + imm) : (pc + 32'd4);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pc <= '0;
        else
            pc <= pcNext;  // One instruction per edge
    end

    // Branch offsets in the ROM are multiples of 4
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc left word alignment");

endmodule

//--- panel/panelFront.sv
`timescale 1ns/100ps

module panelFront #(
    parameter int unsigned scanTicks = 75000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               selNum,    // High picks operand two
    input  logic               selDigit,  // High picks upper nibble
    input  panelPkg::nibble_t  num,
    input  logic               done,
    input  rvPkg::operand_t    gcd,
    output rvPkg::operand_t    num1,
    output rvPkg::operand_t    num2,
    output panelPkg::anodes_t  anodes,
    output panelPkg::segments_t segments
);
    import panelPkg::*;

    localparam int CNT_W = (scanTicks > 1) ? $clog2(scanTicks) : 1;

    logic [CNT_W-1:0] tickCnt;
    logic             scanTick;
    digit_t           digit;
    digit_t           digitNext;
    nibble_t          shownNibble;

    ////////////////////////////////////////////////////////////
    // Operand entry
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            num1 <= '0;
            num2 <= '0;
        end
        else if (!done)  // Frozen while the core works
        begin
            if (selNum)
            begin
                if (selDigit)
                    num2[7:4] <= num;
                else
                    num2[3:0] <= num;
            end
            else
            begin
                if (selDigit)
                    num1[7:4] <= num;
                else
                    num1[3:0] <= num;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Digit scanner
    ////////////////////////////////////////////////////////////
    assign scanTick = (tickCnt == CNT_W'(scanTicks - 1));

    always_comb
    begin
        case (digit)
            DIG_NUM1_HI: digitNext = DIG_NUM1_LO;
            DIG_NUM1_LO: digitNext = DIG_NUM2_HI;
            DIG_NUM2_HI: digitNext = DIG_NUM2_LO;
            DIG_NUM2_LO: digitNext = DIG_GCD_HI;
            DIG_GCD_HI:  digitNext = DIG_GCD_LO;
            default:     digitNext = DIG_NUM1_HI;  // Wrap
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tickCnt <= '0;
            digit   <= DIG_NUM1_HI;
        end
        else if (scanTick)
        begin
            tickCnt <= '0;
            digit   <= digitNext;
        end
        else
        begin
            tickCnt <= tickCnt + 1'b1;
        end
    end

    // Nibble for the lit digit
    always_comb
    begin
        case (digit)
            DIG_NUM1_HI: shownNibble = num1[7:4];
            DIG_NUM1_LO: shownNibble = num1[3:0];
            DIG_NUM2_HI: shownNibble = num2[7:4];
            DIG_NUM2_LO: shownNibble = num2[3:0];
            DIG_GCD_HI:  shownNibble = gcd[7:4];
            default:     shownNibble = gcd[3:0];
        endcase
    end

    assign segments = SEG_TABLE[shownNibble];
    assign anodes   = ANODE_TABLE[digit];

    // Table and state must keep one digit lit at a time
    assert property (@(posedge clk) disable iff (rst) $onehot(~anodes))
        else $error("anode pattern does not light exactly one digit");

endmodule

//--- src/gcdSystem.sv
`timescale 1ns/100ps

module gcdSystem #(
    parameter int unsigned scanTicks = 75000  // clk cycles per digit
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            selNum,
    input  logic            selDigit,
    input  logic [3:0]      num,       // Entry nibble
    input  logic            done,      // Level, operands valid
    output logic [7:0]      anodes,
    output logic [6:0]      segments,
    output rvPkg::operand_t gcd
);
    import rvPkg::*;

    operand_t num1;  // Panel to core
    operand_t num2;

    rvCore uCore (
        .clk(clk), .rst(rst), .done(done), .num1(num1), .num2(num2), .gcd(gcd)
    );

    panelFront #(.scanTicks(scanTicks)) uPanel (
        .clk(clk), .rst(rst), .selNum(selNum), .selDigit(selDigit), .num(num),
        .done(done), .gcd(gcd), .num1(num1), .num2(num2),
        .anodes(anodes), .segments(segments)
    );

endmodule

//--- verif/gcdSystemTb.sv
`timescale 1ns/100ps

module gcdSystemTb;
    import rvPkg::*;
    import panelPkg::*;

    localparam int unsigned SCAN_TICKS = 4;
    localparam int RUNS            = 4;
    localparam int ENTRY_CYCLES    = 16;           // Scratch and real writes plus settle time
    localparam int RESULT_BOUND    = 8 + 4 * 255;  // Worst case subtract loop
    localparam int HOLD_CYCLES     = 30;           // Longer than one scan round
    localparam int WATCHDOG_CYCLES = RUNS * (ENTRY_CYCLES + 1100) + 50;

    logic      clk;
    logic      rst;
    logic      selNum;
    logic      selDigit;
    nibble_t   num;
    logic      done;
    anodes_t   anodes;
    segments_t segments;
    operand_t  gcd;

    integer   seed;
    int       doneCycles;  // Cycles since done rose
    operand_t modNum1;     // Operands as the stimulus wrote them
    operand_t modNum2;
    operand_t expGcd;

    gcdSystem #(.scanTicks(SCAN_TICKS)) dut (
        .clk(clk), .rst(rst), .selNum(selNum), .selDigit(selDigit), .num(num),
        .done(done), .anodes(anodes), .segments(segments), .gcd(gcd)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    // Euclid by remainder
    function automatic operand_t euclidGcd(input operand_t a, input operand_t b);
        operand_t x;
        operand_t y;
        operand_t t;
        x = a;
        y = b;
        while (y != 0)
        begin
            t = x % y;
            x = y;
            y = t;
        end
        return x;
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            modNum1 <= '0;
            modNum2 <= '0;
        end
        else if (!done)
        begin
            case ({selNum, selDigit})
                2'b00:   modNum1[3:0] <= num;
                2'b01:   modNum1[7:4] <= num;
                2'b10:   modNum2[3:0] <= num;
                default: modNum2[7:4] <= num;
            endcase
        end
    end

    assign expGcd = euclidGcd(modNum1, modNum2);

    always @(posedge clk)
    begin
        if (rst || !done)
            doneCycles <= 0;
        else
            doneCycles <= doneCycles + 1;
    end

    task automatic reportError(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    // State right after reset release
    assert property (@(posedge clk) $fell(rst) |-> gcd == '0
            && anodes == ANODE_TABLE[DIG_NUM1_HI] && segments == SEG_TABLE[0])
        else reportError("display or result wrong after reset");

    assert property (@(posedge clk) disable iff (rst)
            dut.num1 == modNum1 && dut.num2 == modNum2)
        else reportError("panel operand differs from entered nibbles");

    assert property (@(posedge clk) disable iff (rst) done |=> $stable(dut.num1)
            && $stable(dut.num2))
        else reportError("entry write taken while done high");

    // Operand digits
    assert property (@(posedge clk) disable iff (rst) anodes == ANODE_TABLE[DIG_NUM1_HI]
            |-> segments == SEG_TABLE[modNum1[7:4]])
        else reportError("operand one high digit glyph wrong");
    assert property (@(posedge clk) disable iff (rst) anodes == ANODE_TABLE[DIG_NUM1_LO]
            |-> segments == SEG_TABLE[modNum1[3:0]])
        else reportError("operand one low digit glyph wrong");
    assert property (@(posedge clk) disable iff (rst) anodes == ANODE_TABLE[DIG_NUM2_HI]
            |-> segments == SEG_TABLE[modNum2[7:4]])
        else reportError("operand two high digit glyph wrong");
    assert property (@(posedge clk) disable iff (rst) anodes == ANODE_TABLE[DIG_NUM2_LO]
            |-> segments == SEG_TABLE[modNum2[3:0]])
        else reportError("operand two low digit glyph wrong");

    // Result digits follow the gcd port
    assert property (@(posedge clk) disable iff (rst) anodes == ANODE_TABLE[DIG_GCD_HI]
            |-> segments == SEG_TABLE[gcd[7:4]])
        else reportError("result high digit glyph wrong");
    assert property (@(posedge clk) disable iff (rst) anodes == ANODE_TABLE[DIG_GCD_LO]
            |-> segments == SEG_TABLE[gcd[3:0]])
        else reportError("result low digit glyph wrong");

    assert property (@(posedge clk) disable iff (rst) $onehot(~anodes))
        else reportError("anodes do not light exactly one digit");

    assert property (@(posedge clk) disable iff (rst) !done ##1 !done |-> $stable(gcd))
        else reportError("gcd changed while done low");

    // Result in place once the bound has run out
    assert property (@(posedge clk) disable iff (rst)
            (done && doneCycles == RESULT_BOUND) |-> (gcd == expGcd))
        else reportError("gcd missed the expected value within the bound");

    // Then it stays put while done is high
    assert property (@(posedge clk) disable iff (rst)
            (done && doneCycles > RESULT_BOUND) |-> $stable(gcd))
        else reportError("gcd moved after reaching the result");

    // Core internals
    assert property (@(posedge clk) disable iff (rst) dut.uCore.pc[1:0] == 2'b00)
        else reportError("pc not word aligned");

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    function automatic operand_t drawOperand();
        logic [31:0] r;
        r = $random(seed);
        while (r[7:0] == 8'h00)
            r = $random(seed);
        return r[7:0];
    endfunction

    task automatic driveEntry(input logic pickTwo, input logic pickHigh, input nibble_t value);
        @(negedge clk);
        done     = 1'b0;
        selNum   = pickTwo;
        selDigit = pickHigh;
        num      = value;
    endtask

    task automatic enterOperands(input operand_t a, input operand_t b);
        logic [31:0] r;
        repeat (4)
        begin
            r = $random(seed);
            driveEntry(r[0], r[1], r[7:4]);  // Scratch values get overwritten
        end
        driveEntry(1'b0, 1'b1, a[7:4]);
        driveEntry(1'b0, 1'b0, a[3:0]);
        driveEntry(1'b1, 1'b1, b[7:4]);
        driveEntry(1'b1, 1'b0, b[3:0]);
        repeat (ENTRY_CYCLES - 8) @(negedge clk);  // Core back in its wait loop
    endtask

    // Random entry traffic while done is high
    task automatic driveIgnoredEntry();
        logic [31:0] r;
        @(negedge clk);
        r        = $random(seed);
        selNum   = r[8];
        selDigit = r[9];
        num      = r[3:0];
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("tests failed");
        $fatal(1, "watchdog timeout");
    end

    initial
    begin
        operand_t a;
        operand_t b;
        seed     = 32'hec8e;
        rst      = 1'b1;
        selNum   = 1'b0;
        selDigit = 1'b0;
        num      = '0;
        done     = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int run = 0; run < RUNS; run++)
        begin
            a = drawOperand();
            b = drawOperand();
            enterOperands(a, b);
            @(negedge clk);
            done = 1'b1;
            // gcd has no end marker so the full bound is waited out
            repeat (RESULT_BOUND + HOLD_CYCLES) driveIgnoredEntry();
        end

        @(negedge clk);
        done = 1'b0;
        repeat (ENTRY_CYCLES) @(negedge clk);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- gcdSystem.f
common/rvPkg.sv
common/panelPkg.sv
core/gcdProgramRom.sv
core/instrDecoder.sv
core/regFile.sv
core/execUnit.sv
core/rvCore.sv
panel/panelFront.sv
src/gcdSystem.sv
verif/gcdSystemTb.sv

//--- Bender.yml
package:
  name: gcdSystem

sources:
  - files:
      - common/rvPkg.sv
      - common/panelPkg.sv
      - core/gcdProgramRom.sv
      - core/instrDecoder.sv
      - core/regFile.sv
      - core/execUnit.sv
      - core/rvCore.sv
      - panel/panelFront.sv
      - src/gcdSystem.sv
  - target: test
    files:
      - verif/gcdSystemTb.sv
